// File: run_sim.sh
#!/bin/sh
# build and run the TCB memory simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tcb_mem_tb -f verilog.f -o tcb_mem_sim \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/tcb_mem_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Done: no errors" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: tcb_mem_arb.sv
// TCB two port arbiter
`timescale 1ns/1ps

module tcb_mem_arb (
  input  logic                    tcb,
  input  logic                    rst,
  // port 0 request
  input  logic                    p0_vld,
  input  logic                    p0_wen,
  input  tcb_pkg::adr_t           p0_adr,
  input  tcb_pkg::ben_t           p0_ben,
  input  tcb_pkg::wdt_t           p0_wdt,
  // port 1 request
  input  logic                    p1_vld,
  input  logic                    p1_wen,
  input  tcb_pkg::adr_t           p1_adr,
  input  tcb_pkg::ben_t           p1_ben,
  input  tcb_pkg::wdt_t           p1_wdt,
  // handshake back to the managers
  output logic                    p0_rdy,
  output logic                    p1_rdy,
  // granted request
  output logic                    gnt_vld,
  output logic                    gnt_wen,
  output tcb_pkg::adr_t           gnt_adr,
  output tcb_pkg::ben_t           gnt_ben,
  output tcb_pkg::wdt_t           gnt_wdt,
  // read tag, aligned with bank data
  output logic                    rsp_vld,
  output logic                    rsp_port,
  output logic [tcb_pkg::BEW-1:0] rsp_lanes
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // priority state
  ////////////////////////////////////////////////////////////////////

  arb_state_t state;

  // lone valid port always wins, tie goes to state
  assign p0_rdy = p0_vld & (~p1_vld | (state == PRI_P0));
  assign p1_rdy = p1_vld & (~p0_vld | (state == PRI_P1));

  // flip priority only after a tie
  always_ff @(posedge tcb) begin
    if (rst) begin
      state <= PRI_P0;
    end else if (p0_vld && p1_vld) begin
      state <= (state == PRI_P0) ? PRI_P1 : PRI_P0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // request mux
  ////////////////////////////////////////////////////////////////////

  // at most one rdy is high, so p1_rdy selects
  assign gnt_vld = p0_rdy | p1_rdy;
  assign gnt_wen = p1_rdy ? p1_wen : p0_wen;
  assign gnt_adr = p1_rdy ? p1_adr : p0_adr;
  assign gnt_ben = p1_rdy ? p1_ben : p0_ben;
  assign gnt_wdt = p1_rdy ? p1_wdt : p0_wdt;

  ////////////////////////////////////////////////////////////////////
  // read tag
  ////////////////////////////////////////////////////////////////////

  // valid only for reads
  always_ff @(posedge tcb) begin
    if (rst) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= gnt_vld & ~gnt_wen;
    end
  end

  // owner and lane mask, only looked at with rsp_vld
  always_ff @(posedge tcb) begin
    rsp_port  <= p1_rdy;
    rsp_lanes <= lane_en(gnt_adr, gnt_ben);
  end

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  // one grant per cycle
  a_rdy_onehot: assert property (@(posedge tcb) disable iff (rst)
    !(p0_rdy && p1_rdy));

  // stalled managers keep their request
  a_p0_hold: assert property (@(posedge tcb) disable iff (rst)
    (p0_vld && !p0_rdy) |=> ($stable(p0_adr) && $stable(p0_wdt)));

  a_p1_hold: assert property (@(posedge tcb) disable iff (rst)
    (p1_vld && !p1_rdy) |=> ($stable(p1_adr) && $stable(p1_wdt)));

endmodule : tcb_mem_arb

// File: tcb_mem_bank.sv
// TCB byte lane storage
`timescale 1ns/1ps

module tcb_mem_bank (
  input  logic                    tcb,
  // per lane access
  input  tcb_mem_pkg::row_t       lane_row [0:tcb_pkg::BEW-1],
  input  logic [tcb_pkg::BEW-1:0] lane_wen,
  input  logic [tcb_pkg::BEW-1:0] lane_ren,
  // write data, already lane ordered
  input  tcb_pkg::wdt_t           wdt,
  // read data, one cycle after the request
  output tcb_pkg::wdt_t           bank_rdt
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // lane arrays
  ////////////////////////////////////////////////////////////////////

  // registered read byte per lane
  logic [SLW-1:0] rd_q [0:BEW-1];

  for (genvar k = 0; k < BEW; k++) begin : g_lane

    // storage for this lane, ROWS bytes
    logic [SLW-1:0] mem [0:ROWS-1];

    // write at the transfer edge
    always_ff @(posedge tcb) begin
      if (lane_wen[k]) begin
        mem[lane_row[k]] <= wdt[k*SLW +: SLW];
      end
    end

    // synchronous read, byte held when lane idle
    always_ff @(posedge tcb) begin
      if (lane_ren[k]) begin
        rd_q[k] <= mem[lane_row[k]];
      end
    end

  end : g_lane

  ////////////////////////////////////////////////////////////////////
  // output word
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < BEW; k++) begin
      bank_rdt[k*SLW +: SLW] = rd_q[k];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  // mapper gives each lane one direction per cycle
  a_lane_dir: assert property (@(posedge tcb)
    (lane_wen & lane_ren) == '0);

endmodule : tcb_mem_bank

// File: tcb_mem_lane.sv
// TCB address to lane mapper
`timescale 1ns/1ps

module tcb_mem_lane (
  input  logic                    gnt_vld,
  input  logic                    gnt_wen,
  input  tcb_pkg::adr_t           gnt_adr,
  input  tcb_pkg::ben_t           gnt_ben,
  // per lane row and enables
  output tcb_mem_pkg::row_t       lane_row [0:tcb_pkg::BEW-1],
  output logic [tcb_pkg::BEW-1:0] lane_wen,
  output logic [tcb_pkg::BEW-1:0] lane_ren
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////

  lane_t             off;
  row_t              row_base;
  row_t              row_next;
  logic [BEW-1:0]    en;

  // byte offset inside the row
  assign off = gnt_adr[$bits(lane_t)-1:0];

  // row index, upper bits dropped so SIZ wraps
  assign row_base = gnt_adr[$bits(lane_t) +: $bits(row_t)];

  // next row, wraps at ROWS
  assign row_next = row_t'(row_base + 1'b1);

  ////////////////////////////////////////////////////////////////////
  // per lane row
  ////////////////////////////////////////////////////////////////////

  // lanes below the offset belong to the following row
  for (genvar k = 0; k < BEW; k++) begin : g_row
    assign lane_row[k] = (lane_t'(k) < off) ? row_next : row_base;
  end

  ////////////////////////////////////////////////////////////////////
  // enables
  ////////////////////////////////////////////////////////////////////

  // nothing enabled without a grant
  assign en = lane_en(gnt_adr, gnt_ben) & {BEW{gnt_vld}};

  // split by direction
  assign lane_wen = en & {BEW{gnt_wen}};
  assign lane_ren = en & {BEW{~gnt_wen}};

endmodule : tcb_mem_lane

// File: tcb_mem_pkg.sv
// TCB memory definitions

package tcb_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////////////////////////

  // memory size in bytes, addresses wrap modulo this
  localparam int unsigned SIZ = 1024;
  // rows in each byte lane
  localparam int unsigned ROWS = SIZ / tcb_pkg::BEW;

  // row index inside one lane
  typedef logic [$clog2(ROWS)-1:0] row_t;

  // lane index, also the byte offset inside a row
  typedef logic [$clog2(tcb_pkg::BEW)-1:0] lane_t;

  // port that wins when both are valid
  typedef enum logic {
    PRI_P0,
    PRI_P1
  } arb_state_t;

  //////////////////////////////////////////////////////////////////////
  // lane enables from address and byte enables
  //////////////////////////////////////////////////////////////////////

  // lane k is enabled by ben bit (k - adr) mod BEW
  // i.e. ben rotated up by the byte offset
  function automatic logic [tcb_pkg::BEW-1:0] lane_en (
    input tcb_pkg::adr_t adr,
    input tcb_pkg::ben_t ben
  );
    lane_t                   off;
    logic [tcb_pkg::BEW-1:0] en;
    off = adr[$bits(lane_t)-1:0];
    for (int k = 0; k < tcb_pkg::BEW; k++) begin
      // subtraction truncated to the lane width wraps mod BEW
      en[k] = ben[lane_t'(k - off)];
    end
    return en;
  endfunction : lane_en

endpackage : tcb_mem_pkg

// File: tcb_mem_rdp.sv
// TCB read data pipeline
`timescale 1ns/1ps

module tcb_mem_rdp (
  input  logic                    tcb,
  input  logic                    rst,
  // read tag from the arbiter
  input  logic                    rsp_vld,
  input  logic                    rsp_port,
  input  logic [tcb_pkg::BEW-1:0] rsp_lanes,
  // raw bank data, aligned with the tag
  input  tcb_pkg::wdt_t           bank_rdt,
  // held read data per port
  output tcb_pkg::wdt_t           p0_rdt,
  output tcb_pkg::wdt_t           p1_rdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // lane mask
  ////////////////////////////////////////////////////////////////////

  wdt_t rdt_msk;

  // disabled lanes read zero
  always_comb begin
    for (int k = 0; k < BEW; k++) begin
      rdt_msk[k*SLW +: SLW] = rsp_lanes[k] ? bank_rdt[k*SLW +: SLW] : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // port output registers
  ////////////////////////////////////////////////////////////////////

  // only the owner updates
  // the other port keeps its last response
  always_ff @(posedge tcb) begin
    if (rst) begin
      p0_rdt <= '0;
      p1_rdt <= '0;
    end else if (rsp_vld) begin
      if (rsp_port) begin
        p1_rdt <= rdt_msk;
      end else begin
        p0_rdt <= rdt_msk;
      end
    end
  end

endmodule : tcb_mem_rdp

// File: tcb_mem_tb.sv
// TCB memory testbench
`timescale 1ns/1ps

module tcb_mem_tb;

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // setup
  //////////////////////////////////////////////////////////////////////

  // 436 transfers take at most two cycles each in the shared phase
  // limit leaves a wide margin over that
  localparam int TMO = 2000;

  // stimulus phases
  typedef enum int {PH_FILL, PH_ALIGN, PH_PART, PH_MISAL, PH_BOTH} phase_t;

  // one expected read response
  typedef struct packed {
    logic        port;
    adr_t        adr;
    wdt_t        exp;
    logic [31:0] chk;
  } rd_chk_t;

  logic tcb;
  logic rst;
  // port requests indexed by port
  logic vld [0:1] = '{default: 1'b0};
  logic wen [0:1] = '{default: 1'b0};
  adr_t adr [0:1] = '{default: '0};
  ben_t ben [0:1] = '{default: '0};
  wdt_t wdt [0:1] = '{default: '0};
  logic p0_rdy;
  logic p1_rdy;
  wdt_t p0_rdt;
  wdt_t p1_rdt;

  // reference memory with one byte per address
  logic [7:0] ref_mem [0:SIZ-1];
  rd_chk_t    chk_q [$];
  // expected rdt per port between its own reads
  wdt_t       hold [0:1] = '{default: '0};
  phase_t     phase;
  logic       live;
  int         seed = 35;
  int         cyc = 0;
  int         errors = 0;
  int         checks = 0;
  // request counts kept by the driver and bounded by the sequence
  int         issued [0:1] = '{default: 0};
  int         start [0:1];
  int         total [0:1];
  int         wait_cnt [0:1] = '{default: 0};
  logic       go [0:1] = '{default: 1'b0};

  tcb_mem_top UUT (
    .tcb    (tcb),
    .rst    (rst),
    .p0_vld (vld[0]),
    .p0_wen (wen[0]),
    .p0_adr (adr[0]),
    .p0_ben (ben[0]),
    .p0_wdt (wdt[0]),
    .p0_rdy (p0_rdy),
    .p0_rdt (p0_rdt),
    .p1_vld (vld[1]),
    .p1_wen (wen[1]),
    .p1_adr (adr[1]),
    .p1_ben (ben[1]),
    .p1_wdt (wdt[1]),
    .p1_rdy (p1_rdy),
    .p1_rdt (p1_rdt)
  );

  // 40 ns clock
  initial begin
    tcb = 1'b0;
    forever #20 tcb = ~tcb;
  end

  always @(posedge tcb) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // byte adr+b lands in lane (adr+b) mod 4 and wraps at SIZ
  task automatic model_write(input adr_t a, input ben_t be, input wdt_t d);
    adr_t ba;
    for (int b = 0; b < BEW; b++) begin
      ba = a + adr_t'(b);
      if (be[b]) begin
        ref_mem[ba % SIZ] = d[(ba % BEW) * 8 +: 8];
      end
    end
  endtask

  // disabled lanes stay zero
  function automatic wdt_t ref_read(input adr_t a, input ben_t be);
    wdt_t w;
    adr_t ba;
    w = '0;
    for (int b = 0; b < BEW; b++) begin
      ba = a + adr_t'(b);
      if (be[b]) begin
        w[(ba % BEW) * 8 +: 8] = ref_mem[ba % SIZ];
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic new_request(input int p);
    logic [31:0] r;
    logic [31:0] r2;
    logic [9:0]  low;
    int          i;
    r  = $random(seed);
    r2 = $random(seed);
    i  = issued[p] - start[p];
    case (phase)
      PH_FILL: begin
        // low 256 bytes and top 32 bytes so no read sees unwritten bytes
        wen[p] = 1'b1;
        ben[p] = 4'hF;
        if (i < 64) begin
          adr[p] = adr_t'(i * 4);
        end else begin
          adr[p] = adr_t'(32'h3E0 + (i - 64) * 4);
        end
      end
      PH_ALIGN: begin
        // 16 word writes then read back in the 64 bytes owned by the port
        wen[p] = (i < 16);
        ben[p] = 4'hF;
        adr[p] = adr_t'(64 + p * 64 + (i % 16) * 4);
      end
      PH_PART: begin
        // partial enables merge into aligned words 0xc0 to 0xff
        wen[p] = r[0];
        ben[p] = r[7:4];
        adr[p] = {24'h0, 2'b11, r[13:10], 2'b00};
      end
      PH_MISAL: begin
        // row crossing near 0x40 and the wrap at the top of memory
        low    = (r[1] ? 10'h3F8 : 10'h03C) + {7'd0, r[4:2]};
        wen[p] = r[0];
        ben[p] = r[8:5];
        adr[p] = {r2[31:10], low};
      end
      default: begin
        // shared window so the ports hit each other's bytes
        wen[p] = r[0];
        ben[p] = r[8:5];
        adr[p] = {r2[31:10], 3'b000, r[15:9]} + adr_t'(64);
      end
    endcase
    wdt[p] = $random(seed);
  endtask

  // driver and transfer monitor for both ports
  always @(negedge tcb) begin
    logic    rdy_p;
    rd_chk_t c;
    if (live) begin
      for (int p = 0; p < 2; p++) begin
        // transfer of the last rising edge
        if (go[p]) begin
          if (wen[p]) begin
            model_write(adr[p], ben[p], wdt[p]);
          end else begin
            c.port = (p == 1);
            c.adr  = adr[p];
            c.exp  = ref_read(adr[p], ben[p]);
            c.chk  = 32'(cyc + DLY);
            chk_q.push_back(c);
          end
          vld[p] = 1'b0;
        end
        // next request or hold the stalled one
        if (!vld[p] && issued[p] < total[p]) begin
          new_request(p);
          vld[p]    = 1'b1;
          issued[p] = issued[p] + 1;
        end
      end
      // rdy settles shortly after the drive
      #1;
      for (int p = 0; p < 2; p++) begin
        rdy_p = (p == 0) ? p0_rdy : p1_rdy;
        go[p] = vld[p] & rdy_p;
        if (rdy_p && !vld[p]) begin
          $display("rdy high on port %0d without a valid request at %0t", p, $time);
          errors++;
        end
        wait_cnt[p] = (vld[p] && !rdy_p) ? wait_cnt[p] + 1 : 0;
        if (wait_cnt[p] > 1) begin
          $display("port %0d waited more than one cycle for rdy at %0t", p, $time);
          errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checker
  //////////////////////////////////////////////////////////////////////

  // data due at edge chk is sampled at the falling edge before it
  always @(negedge tcb) begin
    wdt_t    got;
    logic    due;
    rd_chk_t c;
    if (live) begin
      due = (chk_q.size() > 0) && (chk_q[0].chk == 32'(cyc + 1));
      if (due) begin
        c = chk_q.pop_front();
      end
      for (int p = 0; p < 2; p++) begin
        got = p ? p1_rdt : p0_rdt;
        checks++;
        if (due && c.port == (p == 1)) begin
          if (got !== c.exp) begin
            $display("mismatch at %0t: port %0d adr %h expected %h got %h",
                     $time, p, c.adr, c.exp, got);
            errors++;
          end
          hold[p] = c.exp;
        end else if (got !== hold[p]) begin
          // other port's response must not touch this one
          $display("mismatch at %0t: port %0d rdt moved without own read, expected %h got %h",
                   $time, p, hold[p], got);
          errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  task automatic run_phase(input phase_t ph, input int n0, input int n1);
    phase    = ph;
    start[0] = issued[0];
    start[1] = issued[1];
    total[0] = issued[0] + n0;
    total[1] = issued[1] + n1;
    @(posedge tcb);
    // drain requests and pending reads
    while (issued[0] < total[0] || issued[1] < total[1] || vld[0] || vld[1]
           || chk_q.size() > 0) begin
      @(posedge tcb);
    end
  endtask

  initial begin
    rst      = 1'b1;
    live     = 1'b0;
    phase    = PH_FILL;
    start[0] = 0;
    start[1] = 0;
    total[0] = 0;
    total[1] = 0;
    repeat (3) @(posedge tcb);
    @(negedge tcb);
    rst = 1'b0;
    @(posedge tcb);
    live = 1'b1;
    run_phase(PH_FILL, 72, 0);
    run_phase(PH_ALIGN, 32, 0);
    run_phase(PH_ALIGN, 0, 32);
    run_phase(PH_PART, 40, 0);
    run_phase(PH_MISAL, 0, 60);
    run_phase(PH_BOTH, 100, 100);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // hang guard
  initial begin
    while (cyc < TMO) @(posedge tcb);
    $display("timeout: transfers did not complete");
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule : tcb_mem_tb

// File: tcb_mem_top.sv
// TCB dual port memory top
`timescale 1ns/1ps

module tcb_mem_top (
  input  logic          tcb,
  input  logic          rst,
  // port 0
  input  logic          p0_vld,
  input  logic          p0_wen,
  input  tcb_pkg::adr_t p0_adr,
  input  tcb_pkg::ben_t p0_ben,
  input  tcb_pkg::wdt_t p0_wdt,
  output logic          p0_rdy,
  output tcb_pkg::wdt_t p0_rdt,
  // port 1
  input  logic          p1_vld,
  input  logic          p1_wen,
  input  tcb_pkg::adr_t p1_adr,
  input  tcb_pkg::ben_t p1_ben,
  input  tcb_pkg::wdt_t p1_wdt,
  output logic          p1_rdy,
  output tcb_pkg::wdt_t p1_rdt
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////////////

  // granted request
  logic           gnt_vld;
  logic           gnt_wen;
  adr_t           gnt_adr;
  ben_t           gnt_ben;
  wdt_t           gnt_wdt;

  // lane side of the bank
  row_t           lane_row [0:BEW-1];
  logic [BEW-1:0] lane_wen;
  logic [BEW-1:0] lane_ren;
  wdt_t           bank_rdt;

  // read tag
  logic           rsp_vld;
  logic           rsp_port;
  logic [BEW-1:0] rsp_lanes;

  ////////////////////////////////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////////////////////////////////

  tcb_mem_arb u_arb (
    .tcb       (tcb),
    .rst       (rst),
    .p0_vld    (p0_vld),
    .p0_wen    (p0_wen),
    .p0_adr    (p0_adr),
    .p0_ben    (p0_ben),
    .p0_wdt    (p0_wdt),
    .p1_vld    (p1_vld),
    .p1_wen    (p1_wen),
    .p1_adr    (p1_adr),
    .p1_ben    (p1_ben),
    .p1_wdt    (p1_wdt),
    .p0_rdy    (p0_rdy),
    .p1_rdy    (p1_rdy),
    .gnt_vld   (gnt_vld),
    .gnt_wen   (gnt_wen),
    .gnt_adr   (gnt_adr),
    .gnt_ben   (gnt_ben),
    .gnt_wdt   (gnt_wdt),
    .rsp_vld   (rsp_vld),
    .rsp_port  (rsp_port),
    .rsp_lanes (rsp_lanes)
  );

  ////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////

  tcb_mem_lane u_lane (
    .gnt_vld  (gnt_vld),
    .gnt_wen  (gnt_wen),
    .gnt_adr  (gnt_adr),
    .gnt_ben  (gnt_ben),
    .lane_row (lane_row),
    .lane_wen (lane_wen),
    .lane_ren (lane_ren)
  );

  // write data goes straight in, lanes match address order
  tcb_mem_bank u_bank (
    .tcb      (tcb),
    .lane_row (lane_row),
    .lane_wen (lane_wen),
    .lane_ren (lane_ren),
    .wdt      (gnt_wdt),
    .bank_rdt (bank_rdt)
  );

  tcb_mem_rdp u_rdp (
    .tcb       (tcb),
    .rst       (rst),
    .rsp_vld   (rsp_vld),
    .rsp_port  (rsp_port),
    .rsp_lanes (rsp_lanes),
    .bank_rdt  (bank_rdt),
    .p0_rdt    (p0_rdt),
    .p1_rdt    (p1_rdt)
  );

endmodule : tcb_mem_top

// File: tcb_pkg.sv
// TCB bus definitions

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // address width in bits
  localparam int unsigned ADW = 32;
  // byte lanes per data word
  localparam int unsigned BEW = 4;
  // bits per byte lane
  localparam int unsigned SLW = 8;
  // data width, all lanes together
  localparam int unsigned DTW = BEW * SLW;

  //////////////////////////////////////////////////////////////////////
  // response timing
  //////////////////////////////////////////////////////////////////////

  // edges from the transfer to valid read data
  localparam int unsigned DLY = 2;

  //////////////////////////////////////////////////////////////////////
  // bus field types
  //////////////////////////////////////////////////////////////////////

  // byte address
  typedef logic [ADW-1:0] adr_t;

  // byte enables, bit b is the byte at adr+b
  typedef logic [BEW-1:0] ben_t;

  // write/read data, lane k in bits 8k+7:8k
  // a lane holds the byte whose address is k mod BEW
  typedef logic [DTW-1:0] wdt_t;

endpackage : tcb_pkg

// File: verilog.f
tcb_pkg.sv
tcb_mem_pkg.sv
tcb_mem_arb.sv
tcb_mem_lane.sv
tcb_mem_bank.sv
tcb_mem_rdp.sv
tcb_mem_top.sv
tcb_mem_tb.sv
